//--- bench/tb_timetag.sv
`default_nettype none

module tb_timetag;
	timeunit 1ns;
	timeprecision 1ps;
	import timetag_pkg::*;

	// Roughly twice what the five tests need together
	localparam int TIMEOUT_CYCLES = 2 * (40 + 60 + 260 + 320 + 150);
	localparam int MSG_WAIT = 200;

	logic            clk;
	logic            rst_n;
	logic            cmd_wr;
	logic [7:0]      cmd_in;
	logic [N_CH-1:0] strobe_in;
	logic [N_CH-1:0] delta_in;
	logic            up_rdy;
	logic [7:0]      up_data;
	logic            up_end;
	logic            up_is_reply;
	logic            up_ack;
	logic            capture_operate;

	int error_count = 0;
	int check_count = 0;
	int seed = 61;
	int stored_total = 0;
	int cycles = 0;

	// Completed upstream messages, bytes packed MSB first
	logic [47:0] msg_data [$];
	int          msg_len [$];
	bit          msg_reply [$];
	logic [47:0] cur_data = '0;
	int          cur_len = 0;
	bit          cur_reply = 1'b0;

	timetag_top timetag_top_i (
		.clk(clk), .rst_n(rst_n),
		.cmd_wr(cmd_wr), .cmd_in(cmd_in),
		.strobe_in(strobe_in), .delta_in(delta_in),
		.up_rdy(up_rdy), .up_data(up_data),
		.up_end(up_end), .up_is_reply(up_is_reply),
		.up_ack(up_ack), .capture_operate(capture_operate)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Error: simulation timed out after %0d cycles", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	// Byte transfers happen on rising edges with up_rdy and up_ack both high
	always @(posedge clk)
	begin
		if (up_rdy && up_ack)
		begin
			if (cur_len == 0)
				cur_reply = up_is_reply;
			else if (up_is_reply != cur_reply)
			begin
				$display("Error: reply and record bytes interleaved in one message");
				error_count++;
			end
			cur_data = {cur_data[39:0], up_data};
			cur_len++;
			if (up_end)
			begin
				msg_data.push_back(cur_data);
				msg_len.push_back(cur_len);
				msg_reply.push_back(cur_reply);
				cur_data = '0;
				cur_len = 0;
			end
		end
	end

	task automatic check_value(input string name, input logic [47:0] got,
		input logic [47:0] exp);
		check_count++;
		if (got !== exp)
		begin
			$display("FAIL %s: got %0h, expected %0h", name, got, exp);
			error_count++;
		end
	endtask

	function automatic logic [3:0] random_delta();
		logic [31:0] r;
		r = $random(seed);
		return r[3:0];
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Header then payload; returns once capture_operate has settled
	task automatic send_cmd(input logic [2:0] target, input logic [7:0] payload);
		@(negedge clk);
		cmd_wr = 1'b1;
		cmd_in = {5'b0, target};
		@(negedge clk);
		cmd_in = payload;
		@(negedge clk);
		cmd_wr = 1'b0;
		cmd_in = '0;
		idle(2);
	endtask

	task automatic pulse_strobe(input logic [N_CH-1:0] mask, input logic [N_CH-1:0] delta);
		@(negedge clk);
		strobe_in = mask;
		delta_in = delta;
		@(negedge clk);
		strobe_in = '0;
	endtask

	task automatic read_bytes(output logic [47:0] data, output int len, output bit reply);
		int waited;
		@(negedge clk);
		up_ack = 1'b1;
		waited = 0;
		while (msg_data.size() == 0 && waited < MSG_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (msg_data.size() == 0)
		begin
			$display("Error: no upstream message arrived within %0d cycles", MSG_WAIT);
			error_count++;
			data = '0;
			len = 0;
			reply = 1'b0;
		end
		else
		begin
			data = msg_data.pop_front();
			len = msg_len.pop_front();
			reply = msg_reply.pop_front();
		end
	endtask

	task automatic expect_record(input logic exp_lost, input logic [N_CH-1:0] exp_mask,
		input logic [N_CH-1:0] exp_delta, output logic [TS_W-1:0] ts);
		logic [47:0] data;
		int          len;
		bit          reply;
		tt_sample_t  s;
		read_bytes(data, len, reply);
		s = data;
		check_value("record length", len, SAMPLE_BYTES);
		check_value("up_is_reply on record", reply, 1'b0);
		check_value("lost", s.lost, exp_lost);
		check_value("strobes", s.strobes, exp_mask);
		check_value("delta", s.delta, exp_delta);
		ts = s.timestamp;
	endtask

	task automatic expect_reply(input logic [15:0] exp_count, input logic [7:0] exp_status);
		logic [47:0] data;
		int          len;
		bit          reply;
		read_bytes(data, len, reply);
		check_value("reply length", len, 3);
		check_value("up_is_reply on reply", reply, 1'b1);
		check_value("reply count high", data[23:16], exp_count[15:8]);
		check_value("reply count low", data[15:8], exp_count[7:0]);
		check_value("reply status", data[7:0], exp_status);
	endtask

	task automatic test_reset_status();
		check_value("up_rdy", up_rdy, 1'b0);
		check_value("capture_operate", capture_operate, 1'b0);
		send_cmd(TGT_STATUS, 8'h00);
		// Only the empty flag is set
		expect_reply(16'h0000, 8'h20);
	endtask

	task automatic test_capture_control();
		send_cmd(TGT_CAPTURE, 8'h03);
		check_value("capture_operate after start+stop", capture_operate, 1'b0);
		send_cmd(TGT_CAPTURE, 8'h01);
		check_value("capture_operate after start", capture_operate, 1'b1);
		send_cmd(3'd5, 8'h02);
		check_value("capture_operate after target 5", capture_operate, 1'b1);
		send_cmd(TGT_CAPTURE, 8'h03);
		check_value("capture_operate after stop wins", capture_operate, 1'b0);
		send_cmd(3'd6, 8'h01);
		check_value("capture_operate after target 6", capture_operate, 1'b0);
		idle(10);
		check_value("messages after unknown targets", msg_data.size(), 0);
	endtask

	task automatic test_record_timing();
		logic [N_CH-1:0] masks [4];
		logic [N_CH-1:0] deltas [4];
		logic [TS_W-1:0] ts [4];
		logic [TS_W-1:0] ts_clr;
		int              gaps [3];
		int              i;
		masks = '{4'b0001, 4'b0100, 4'b1010, 4'b1000};
		gaps = '{5, 9, 14};
		send_cmd(TGT_CAPTURE, 8'h01);
		idle(100);
		for (i = 0; i < 4; i++)
		begin
			deltas[i] = random_delta();
			pulse_strobe(masks[i], deltas[i]);
			if (i < 3)
				idle(gaps[i] - 2);
		end
		for (i = 0; i < 4; i++)
			expect_record(1'b0, masks[i], deltas[i], ts[i]);
		check_value("timestamp above 90 after idle", ts[0] > 90, 1'b1);
		for (i = 1; i < 4; i++)
			check_value("timestamp gap", ts[i] - ts[i-1], gaps[i-1]);
		send_cmd(TGT_CAPTURE, 8'h04);
		pulse_strobe(4'b0001, deltas[3]);
		expect_record(1'b0, 4'b0001, deltas[3], ts_clr);
		check_value("timestamp below 16 after clear", ts_clr < 16, 1'b1);
		stored_total += 5;
	endtask

	task automatic test_overflow();
		logic [N_CH-1:0] deltas [FIFO_DEPTH + 4];
		logic [N_CH-1:0] d;
		logic [TS_W-1:0] ts;
		logic [TS_W-1:0] ts_prev;
		int              i;
		int              n_stored;
		// The serializer holds one record, the FIFO the next FIFO_DEPTH
		n_stored = FIFO_DEPTH + 1;
		@(negedge clk);
		up_ack = 1'b0;
		for (i = 0; i < FIFO_DEPTH + 4; i++)
		begin
			deltas[i] = random_delta();
			pulse_strobe(4'b0010, deltas[i]);
			idle(1);
		end
		idle(5);
		ts_prev = '0;
		for (i = 0; i < n_stored; i++)
		begin
			expect_record(1'b0, 4'b0010, deltas[i], ts);
			if (i > 0)
				check_value("timestamp gap under back-pressure", ts - ts_prev, 3);
			ts_prev = ts;
		end
		idle(20);
		check_value("records beyond capacity", msg_data.size(), 0);
		d = random_delta();
		pulse_strobe(4'b0100, d);
		expect_record(1'b1, 4'b0100, d, ts);
		d = random_delta();
		pulse_strobe(4'b1000, d);
		expect_record(1'b0, 4'b1000, d, ts);
		stored_total += n_stored + 2;
		send_cmd(TGT_STATUS, 8'h00);
		expect_reply(stored_total[15:0], 8'hA0);
	endtask

	task automatic test_query_during_stream();
		logic [47:0] data;
		int          len;
		bit          reply;
		int          n_reply;
		int          n_sample;
		int          i;
		tt_sample_t  s;
		n_reply = 0;
		n_sample = 0;
		for (i = 0; i < 8; i++)
		begin
			pulse_strobe(4'b0001 << (i % 4), i[3:0]);
			idle(2);
			if (i == 2)
				send_cmd(TGT_STATUS, 8'h00);
		end
		for (i = 0; i < 9; i++)
		begin
			read_bytes(data, len, reply);
			if (reply)
			begin
				check_value("reply length in stream", len, 3);
				n_reply++;
			end
			else
			begin
				s = data;
				check_value("record length in stream", len, SAMPLE_BYTES);
				check_value("strobes in stream", s.strobes, 4'b0001 << (n_sample % 4));
				check_value("delta in stream", s.delta, n_sample[3:0]);
				n_sample++;
			end
		end
		check_value("reply messages", n_reply, 1);
		check_value("record messages", n_sample, 8);
		stored_total += 8;
	endtask

	initial
	begin
		rst_n = 1'b0;
		cmd_wr = 1'b0;
		cmd_in = '0;
		strobe_in = '0;
		delta_in = '0;
		up_ack = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		idle(1);
		test_reset_status();
		test_capture_control();
		test_record_timing();
		test_overflow();
		test_query_during_stream();
		idle(10);
		check_value("leftover messages", msg_data.size(), 0);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/capture_control.sv
`default_nettype none

module capture_control (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire timetag_pkg::tt_cmd_t cmd,
	input  wire                  cmd_valid,
	output logic                 capture_operate,
	output logic                 counter_clear
);
	import timetag_pkg::*;

	logic is_capture;

	assign is_capture = cmd_valid && (cmd.target == TGT_CAPTURE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			capture_operate <= 1'b0;
			counter_clear <= 1'b0;
		end
		else
		begin
			counter_clear <= is_capture && cmd.payload[CAP_CLEAR];
			// Stop overrides start
			if (is_capture && cmd.payload[CAP_STOP])
				capture_operate <= 1'b0;
			else if (is_capture && cmd.payload[CAP_START])
				capture_operate <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/cmd_parser.sv
`default_nettype none

module cmd_parser (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  cmd_wr,
	input  wire  [7:0]           cmd_in,
	output timetag_pkg::tt_cmd_t cmd,
	output logic                 cmd_valid
);

	// High while waiting for the payload byte
	logic       payload_phase;
	logic [2:0] header;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			payload_phase <= 1'b0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= cmd_wr && payload_phase;
			if (cmd_wr)
				payload_phase <= !payload_phase;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_wr && !payload_phase)
			header <= cmd_in[2:0];
		if (cmd_wr && payload_phase)
		begin
			cmd.target <= header;
			cmd.payload <= cmd_in;
		end
	end

endmodule

`default_nettype wire

//--- hw/host_arbiter.sv
`default_nettype none

module host_arbiter (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire timetag_pkg::tt_up_req_t reply_req,
	input  wire timetag_pkg::tt_up_req_t sample_req,
	output logic                         reply_ack,
	output logic                         sample_ack,
	output logic                         up_rdy,
	output logic [7:0]                   up_data,
	output logic                         up_end,
	output logic                         up_is_reply,
	input  wire                          up_ack
);
	import timetag_pkg::*;

	logic       locked;
	logic       grant_reply;
	logic       sel_reply;
	tt_up_req_t granted;

	// Reply wins when idle
	assign sel_reply = locked ? grant_reply : reply_req.rdy;
	assign granted = sel_reply ? reply_req : sample_req;

	// Lock as soon as a byte is offered so it cannot change under back-pressure
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			locked <= 1'b0;
			grant_reply <= 1'b0;
		end
		else
		begin
			if (up_rdy && up_ack && up_end)
				locked <= 1'b0;
			else if (up_rdy)
				locked <= 1'b1;
			if (!locked)
				grant_reply <= sel_reply;
		end
	end

	assign up_rdy = granted.rdy;
	assign up_data = granted.data;
	assign up_end = granted.rdy && granted.last;
	assign up_is_reply = sel_reply;

	assign reply_ack = up_ack && sel_reply;
	assign sample_ack = up_ack && !sel_reply;

endmodule

`default_nettype wire

//--- hw/reply_generator.sv
`default_nettype none

module reply_generator (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire timetag_pkg::tt_cmd_t cmd,
	input  wire                       cmd_valid,
	input  wire  [15:0]               sample_count,
	input  wire                       capture_operate,
	input  wire                       fifo_full,
	input  wire                       fifo_empty,
	output timetag_pkg::tt_up_req_t   req,
	input  wire                       ack
);
	import timetag_pkg::*;

	logic        busy;
	logic [1:0]  idx;
	logic        query;
	logic [15:0] count_q;
	logic [7:0]  status_q;
	logic [7:0]  byte_out;

	// Queries during a pending reply are dropped
	assign query = cmd_valid && (cmd.target == TGT_STATUS) && !busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			idx <= '0;
		end
		else if (query)
		begin
			busy <= 1'b1;
			idx <= '0;
		end
		else if (busy && ack)
		begin
			if (idx == 2'd2)
				busy <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (query)
		begin
			count_q <= sample_count;
			status_q <= {capture_operate, fifo_full, fifo_empty, 5'b0};
		end
	end

	always_comb
	begin
		case (idx)
			2'd0: byte_out = count_q[15:8];
			2'd1: byte_out = count_q[7:0];
			default: byte_out = status_q;
		endcase
	end

	assign req = '{rdy: busy, data: byte_out, last: (idx == 2'd2)};

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`default_nettype none

module sample_fifo (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          wr_en,
	input  wire timetag_pkg::tt_sample_t wr_data,
	input  wire                          rd_en,
	output timetag_pkg::tt_sample_t      rd_data,
	output logic                         full,
	output logic                         empty
);
	import timetag_pkg::*;

	tt_sample_t                    mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   count;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign rd_data = mem[rd_ptr];
	assign full = count[$clog2(FIFO_DEPTH)];
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- hw/sample_serializer.sv
`default_nettype none

module sample_serializer (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          fifo_empty,
	input  wire timetag_pkg::tt_sample_t fifo_data,
	output logic                         fifo_rd,
	output timetag_pkg::tt_up_req_t      req,
	input  wire                          ack
);
	import timetag_pkg::*;

	logic                              busy;
	logic [$bits(tt_sample_t)-1:0]     shreg;
	logic [$clog2(SAMPLE_BYTES)-1:0]   remaining;

	assign fifo_rd = !busy && !fifo_empty;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			remaining <= '0;
		end
		else if (fifo_rd)
		begin
			busy <= 1'b1;
			remaining <= SAMPLE_BYTES[$clog2(SAMPLE_BYTES)-1:0] - 1'b1;
		end
		else if (busy && ack)
		begin
			if (remaining == '0)
				busy <= 1'b0;
			else
				remaining <= remaining - 1'b1;
		end
	end

	// Top byte is always the one on offer
	always_ff @(posedge clk)
	begin
		if (fifo_rd)
			shreg <= fifo_data;
		else if (busy && ack)
			shreg <= shreg << 8;
	end

	assign req = '{
		rdy:  busy,
		data: shreg[$bits(tt_sample_t)-1 -: 8],
		last: (remaining == '0)
	};

endmodule

`default_nettype wire

//--- hw/strobe_tagger.sv
`default_nettype none

module strobe_tagger (
	input  wire  [timetag_pkg::N_CH-1:0] strobe_in,
	input  wire  [timetag_pkg::N_CH-1:0] delta_in,
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          capture_operate,
	input  wire                          counter_clear,
	input  wire                          fifo_full,
	output timetag_pkg::tt_sample_t      sample,
	output logic                         wr_en,
	output logic [15:0]                  sample_count
);
	import timetag_pkg::*;

	logic [N_CH-1:0] strobe_meta;
	logic [N_CH-1:0] strobe_sync;
	logic [N_CH-1:0] strobe_prev;
	logic [N_CH-1:0] delta_meta;
	logic [N_CH-1:0] delta_sync;
	logic [N_CH-1:0] rising;
	logic [TS_W-1:0] timestamp;
	logic            rec_rdy;
	logic [N_CH-1:0] rec_strobes;
	logic [N_CH-1:0] rec_delta;
	logic [TS_W-1:0] rec_ts;
	logic            lost;

	// Same two-flop path for strobe and delta keeps them aligned
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			strobe_meta <= '0;
			strobe_sync <= '0;
			strobe_prev <= '0;
			delta_meta <= '0;
			delta_sync <= '0;
		end
		else
		begin
			strobe_meta <= strobe_in;
			strobe_sync <= strobe_meta;
			strobe_prev <= strobe_sync;
			delta_meta <= delta_in;
			delta_sync <= delta_meta;
		end
	end

	assign rising = strobe_sync & ~strobe_prev;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			timestamp <= '0;
		else if (counter_clear)
			timestamp <= '0;
		else if (capture_operate)
			timestamp <= timestamp + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rec_rdy <= 1'b0;
		else
			rec_rdy <= capture_operate && (|rising);
	end

	always_ff @(posedge clk)
	begin
		if (capture_operate && (|rising))
		begin
			rec_strobes <= rising;
			rec_delta <= delta_sync;
			rec_ts <= timestamp;
		end
	end

	assign wr_en = rec_rdy && !fifo_full;

	// Lost flag rides along with the next stored record
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lost <= 1'b0;
			sample_count <= '0;
		end
		else if (wr_en)
		begin
			lost <= 1'b0;
			sample_count <= sample_count + 1'b1;
		end
		else if (rec_rdy)
			lost <= 1'b1;
	end

	assign sample = {lost, rec_strobes, rec_delta, rec_ts};

endmodule

`default_nettype wire

//--- hw/timetag_pkg.sv
`default_nettype none

package timetag_pkg;

	// Channel and record geometry
	localparam int N_CH = 4;
	localparam int TS_W = 39;
	localparam int SAMPLE_BYTES = 6;
	localparam int FIFO_DEPTH = 16;

	// Command targets
	localparam logic [2:0] TGT_CAPTURE = 3'd0;
	localparam logic [2:0] TGT_STATUS = 3'd1;

	// Target 0 payload bits
	localparam int CAP_START = 0;
	localparam int CAP_STOP = 1;
	localparam int CAP_CLEAR = 2;

	typedef struct packed {
		logic [2:0] target;
		logic [7:0] payload;
	} tt_cmd_t;

	// 48-bit record, sent MSB first
	typedef struct packed {
		logic            lost;
		logic [N_CH-1:0] strobes;
		logic [N_CH-1:0] delta;
		logic [TS_W-1:0] timestamp;
	} tt_sample_t;

	// One byte offered to the host arbiter
	typedef struct packed {
		logic       rdy;
		logic [7:0] data;
		logic       last;
	} tt_up_req_t;

endpackage

`default_nettype wire

//--- hw/timetag_top.sv
`default_nettype none

module timetag_top (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          cmd_wr,
	input  wire  [7:0]                   cmd_in,
	input  wire  [timetag_pkg::N_CH-1:0] strobe_in,
	input  wire  [timetag_pkg::N_CH-1:0] delta_in,
	output logic                         up_rdy,
	output logic [7:0]                   up_data,
	output logic                         up_end,
	output logic                         up_is_reply,
	input  wire                          up_ack,
	output logic                         capture_operate
);
	import timetag_pkg::*;

	tt_cmd_t     cmd;
	logic        cmd_valid;
	logic        counter_clear;
	tt_sample_t  sample;
	logic        wr_en;
	logic [15:0] sample_count;
	logic        fifo_full;
	logic        fifo_empty;
	logic        fifo_rd;
	tt_sample_t  fifo_data;
	tt_up_req_t  sample_req;
	tt_up_req_t  reply_req;
	logic        sample_ack;
	logic        reply_ack;

	cmd_parser cmd_parser_i (
		.clk(clk), .rst_n(rst_n),
		.cmd_wr(cmd_wr), .cmd_in(cmd_in),
		.cmd(cmd), .cmd_valid(cmd_valid)
	);

	capture_control capture_control_i (
		.clk(clk), .rst_n(rst_n),
		.cmd(cmd), .cmd_valid(cmd_valid),
		.capture_operate(capture_operate), .counter_clear(counter_clear)
	);

	strobe_tagger strobe_tagger_i (
		.clk(clk), .rst_n(rst_n),
		.strobe_in(strobe_in), .delta_in(delta_in),
		.capture_operate(capture_operate), .counter_clear(counter_clear),
		.fifo_full(fifo_full),
		.sample(sample), .wr_en(wr_en), .sample_count(sample_count)
	);

	sample_fifo sample_fifo_i (
		.clk(clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_data(sample),
		.rd_en(fifo_rd), .rd_data(fifo_data),
		.full(fifo_full), .empty(fifo_empty)
	);

	sample_serializer sample_serializer_i (
		.clk(clk), .rst_n(rst_n),
		.fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_rd(fifo_rd),
		.req(sample_req), .ack(sample_ack)
	);

	reply_generator reply_generator_i (
		.clk(clk), .rst_n(rst_n),
		.cmd(cmd), .cmd_valid(cmd_valid),
		.sample_count(sample_count), .capture_operate(capture_operate),
		.fifo_full(fifo_full), .fifo_empty(fifo_empty),
		.req(reply_req), .ack(reply_ack)
	);

	host_arbiter host_arbiter_i (
		.clk(clk), .rst_n(rst_n),
		.reply_req(reply_req), .sample_req(sample_req),
		.reply_ack(reply_ack), .sample_ack(sample_ack),
		.up_rdy(up_rdy), .up_data(up_data),
		.up_end(up_end), .up_is_reply(up_is_reply),
		.up_ack(up_ack)
	);

endmodule

`default_nettype wire

//--- vlog.f
hw/timetag_pkg.sv
hw/cmd_parser.sv
hw/capture_control.sv
hw/strobe_tagger.sv
hw/sample_fifo.sv
hw/sample_serializer.sv
hw/reply_generator.sv
hw/host_arbiter.sv
hw/timetag_top.sv
bench/tb_timetag.sv
